// File: common/ntm_forget_pkg.sv
/*
 * Forget-gate shared definitions
 */

package ntm_forget_pkg;

  ////////////////////////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////////////////////////

  // Q8.8 word
  parameter int DATA_W    = 16;
  parameter int FRAC_BITS = 8;  // Fractional bits of Q8.8

  // Row sum of up to a few dozen Q16.16 products
  parameter int ACC_SIZE  = 40;

  // Constant 1.0
  parameter logic [DATA_W-1:0] ONE_Q = 16'h0100;

  ////////////////////////////////////////////////////////////
  // Controller phases
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PHASE_IDLE,         // Waiting for START
    PHASE_INPUT_W,      // W(l,x) * x(x)
    PHASE_READ_K,       // K(l,k) * r(k)
    PHASE_RECURRENT_U,  // U(l,p) * h(p)
    PHASE_BIAS,         // b(l) * 1.0
    PHASE_DRAIN         // Waiting for last f beat
  } phase_t;

  ////////////////////////////////////////////////////////////
  // Operand pair on the MAC stream
  ////////////////////////////////////////////////////////////

  // Matrix element in the upper half
  typedef struct packed {
    logic [DATA_W-1:0] mat;  // W, K, U or b
    logic [DATA_W-1:0] vec;  // x, r, h or 1.0
  } operand_pair_t;

endpackage

// File: common/ntm_stream_if.sv
/*
 * Valid/ready stream
 */

`timescale 1ns/10ps

interface ntm_stream_if #(
  parameter int WIDTH = 16
);

  logic             valid;  // Source has a beat
  logic             ready;  // Sink can take it
  logic [WIDTH-1:0] data;   // Held while valid and not ready
  logic             last;   // Marks end of row or vector

  // Producer side
  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

// File: forget_gate/ntm_forget_gate_vector.sv
/*
 * Forget-gate operand sequencer
 */

`timescale 1ns/10ps

module ntm_forget_gate_vector #(
  parameter int DATA_SIZE = 16,
  parameter int SIZE_X    = 4,
  parameter int SIZE_W    = 3,
  parameter int SIZE_L    = 4
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,

  // Operand stream from outside
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [DATA_SIZE-1:0] in_a,
  input  logic [DATA_SIZE-1:0] in_b,

  // Last f beat handshake, seen at the top
  input  logic                 done_beat,

  ntm_stream_if.source         pair_s
);

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  localparam int MAX_XW   = (SIZE_X > SIZE_W) ? SIZE_X : SIZE_W;
  localparam int MAX_ELEM = (MAX_XW > SIZE_L) ? MAX_XW : SIZE_L;
  localparam int CNT_W    = $clog2(MAX_ELEM + 1);
  localparam int ROW_W    = $clog2(SIZE_L + 1);

  ntm_forget_pkg::phase_t        phase;
  ntm_forget_pkg::operand_pair_t pair;

  logic [CNT_W-1:0] elem_cnt;  // Element within phase
  logic [ROW_W-1:0] row_cnt;   // Row l
  logic             accepting; // Phase takes operands
  logic             is_bias;
  logic             elem_end;  // Last element of the phase
  logic             beat;

  ////////////////////////////////////////////////////////////
  // Stream side
  ////////////////////////////////////////////////////////////

  assign is_bias   = (phase == ntm_forget_pkg::PHASE_BIAS);
  assign accepting = (phase == ntm_forget_pkg::PHASE_INPUT_W)
                  || (phase == ntm_forget_pkg::PHASE_READ_K)
                  || (phase == ntm_forget_pkg::PHASE_RECURRENT_U)
                  || is_bias;

  // Bias is paired with 1.0, in_b not used there
  assign pair.mat = in_a;
  assign pair.vec = is_bias ? ntm_forget_pkg::ONE_Q : in_b;

  assign pair_s.valid = in_valid && accepting;
  assign pair_s.data  = pair;
  assign pair_s.last  = is_bias;          // Closes the row
  assign in_ready     = pair_s.ready && accepting;

  assign beat = pair_s.valid && pair_s.ready;

  always_comb begin
    case (phase)
      ntm_forget_pkg::PHASE_INPUT_W:     elem_end = (elem_cnt == CNT_W'(SIZE_X - 1));
      ntm_forget_pkg::PHASE_READ_K:      elem_end = (elem_cnt == CNT_W'(SIZE_W - 1));
      ntm_forget_pkg::PHASE_RECURRENT_U: elem_end = (elem_cnt == CNT_W'(SIZE_L - 1));
      default:                           elem_end = 1'b1;  // Bias is one beat
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase    <= ntm_forget_pkg::PHASE_IDLE;
      elem_cnt <= '0;
      row_cnt  <= '0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;  // Single-cycle pulse
      case (phase)
        ntm_forget_pkg::PHASE_IDLE: begin
          if (START) begin
            phase    <= ntm_forget_pkg::PHASE_INPUT_W;
            elem_cnt <= '0;
            row_cnt  <= '0;
          end
        end
        ntm_forget_pkg::PHASE_INPUT_W: begin
          if (beat) begin
            elem_cnt <= elem_end ? '0 : elem_cnt + 1'b1;
            if (elem_end) phase <= ntm_forget_pkg::PHASE_READ_K;
          end
        end
        ntm_forget_pkg::PHASE_READ_K: begin
          if (beat) begin
            elem_cnt <= elem_end ? '0 : elem_cnt + 1'b1;
            if (elem_end) phase <= ntm_forget_pkg::PHASE_RECURRENT_U;
          end
        end
        ntm_forget_pkg::PHASE_RECURRENT_U: begin
          if (beat) begin
            elem_cnt <= elem_end ? '0 : elem_cnt + 1'b1;
            if (elem_end) phase <= ntm_forget_pkg::PHASE_BIAS;
          end
        end
        ntm_forget_pkg::PHASE_BIAS: begin
          if (beat) begin
            if (row_cnt == ROW_W'(SIZE_L - 1)) begin
              phase <= ntm_forget_pkg::PHASE_DRAIN;  // Rows still in flight
            end else begin
              row_cnt <= row_cnt + 1'b1;
              phase   <= ntm_forget_pkg::PHASE_INPUT_W;
            end
          end
        end
        ntm_forget_pkg::PHASE_DRAIN: begin
          if (done_beat) begin
            READY <= 1'b1;
            phase <= ntm_forget_pkg::PHASE_IDLE;
          end
        end
        default: phase <= ntm_forget_pkg::PHASE_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/ntm_dot_product_accumulator.sv
/*
 * Row multiply-accumulate
 */

`timescale 1ns/10ps

module ntm_dot_product_accumulator #(
  parameter int DATA_SIZE = 16,
  parameter int SIZE_L    = 4
) (
  input  logic         CLK,
  input  logic         RST,
  ntm_stream_if.sink   pair_s,
  ntm_stream_if.source sum_s
);

  localparam int ACC_W = ntm_forget_pkg::ACC_SIZE;
  localparam int ROW_W = $clog2(SIZE_L + 1);

  // Signed DATA_SIZE limits at accumulator width
  localparam logic signed [ACC_W-1:0] SAT_MAX =
    {{(ACC_W-DATA_SIZE+1){1'b0}}, {(DATA_SIZE-1){1'b1}}};
  localparam logic signed [ACC_W-1:0] SAT_MIN =
    {{(ACC_W-DATA_SIZE+1){1'b1}}, {(DATA_SIZE-1){1'b0}}};

  ntm_forget_pkg::operand_pair_t pair;

  logic signed [2*DATA_SIZE-1:0] product;     // Q16.16
  logic signed [ACC_W-1:0]       acc;
  logic signed [ACC_W-1:0]       row_total;   // acc plus this beat
  logic signed [ACC_W-1:0]       row_scaled;  // Back to Q8.8, floor
  logic        [DATA_SIZE-1:0]   sat_sum;
  logic        [ROW_W-1:0]       row_cnt;
  logic                          beat;
  logic                          sum_valid;
  logic                          sum_last;
  logic        [DATA_SIZE-1:0]   sum_data;

  assign pair    = pair_s.data;
  assign product = $signed(pair.mat) * $signed(pair.vec);

  assign row_total  = acc + {{(ACC_W-2*DATA_SIZE){product[2*DATA_SIZE-1]}}, product};
  assign row_scaled = row_total >>> ntm_forget_pkg::FRAC_BITS;

  always_comb begin
    if (row_scaled > SAT_MAX)      sat_sum = SAT_MAX[DATA_SIZE-1:0];
    else if (row_scaled < SAT_MIN) sat_sum = SAT_MIN[DATA_SIZE-1:0];
    else                           sat_sum = row_scaled[DATA_SIZE-1:0];
  end

  // Hold off while the sum register is full and not taken
  assign pair_s.ready = !sum_valid || sum_s.ready;
  assign beat         = pair_s.valid && pair_s.ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc       <= '0;
      sum_valid <= 1'b0;
      row_cnt   <= '0;
    end else begin
      if (sum_valid && sum_s.ready) sum_valid <= 1'b0;  // Taken
      if (beat) begin
        if (pair_s.last) begin
          acc       <= '0;  // Fresh row
          sum_valid <= 1'b1;
          row_cnt   <= (row_cnt == ROW_W'(SIZE_L - 1)) ? '0 : row_cnt + 1'b1;
        end else begin
          acc <= row_total;
        end
      end
    end
  end

  // Row sum register
  always_ff @(posedge CLK) begin
    if (beat && pair_s.last) begin
      sum_data <= sat_sum;
      sum_last <= (row_cnt == ROW_W'(SIZE_L - 1));  // Last row of vector
    end
  end

  assign sum_s.valid = sum_valid;
  assign sum_s.data  = sum_data;
  assign sum_s.last  = sum_last;

endmodule

// File: hdl/ntm_vector_logistic.sv
/*
 * Piecewise-linear logistic
 */

`timescale 1ns/10ps

module ntm_vector_logistic #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  ntm_stream_if.sink           sum_s,
  output logic                 f_valid,
  input  logic                 f_ready,
  output logic [DATA_SIZE-1:0] f_out,
  output logic                 f_last
);

  localparam int FB = ntm_forget_pkg::FRAC_BITS;

  // Segment edges and offsets in Q8.8
  localparam logic [DATA_SIZE-1:0] Z_SAT   = DATA_SIZE'(5 << FB);         // 5.0
  localparam logic [DATA_SIZE-1:0] Z_MID   = DATA_SIZE'(19 << (FB - 3));  // 2.375
  localparam logic [DATA_SIZE-1:0] Z_LOW   = DATA_SIZE'(1 << FB);         // 1.0
  localparam logic [DATA_SIZE-1:0] OFS_MID = DATA_SIZE'(27 << (FB - 5));  // 0.84375
  localparam logic [DATA_SIZE-1:0] OFS_LOW = DATA_SIZE'(5 << (FB - 3));   // 0.625
  localparam logic [DATA_SIZE-1:0] OFS_CTR = DATA_SIZE'(1 << (FB - 1));   // 0.5

  logic [DATA_SIZE-1:0] abs_z;   // Unsigned, so -32768 stays large
  logic [DATA_SIZE-1:0] seg;
  logic                 take;
  logic                 stall;
  logic                 s1_valid, s1_neg, s1_last;
  logic [DATA_SIZE-1:0] s1_seg;

  ////////////////////////////////////////////////////////////
  // Stage one, magnitude and segment
  ////////////////////////////////////////////////////////////

  assign abs_z = sum_s.data[DATA_SIZE-1] ? -sum_s.data : sum_s.data;

  always_comb begin
    if (abs_z >= Z_SAT)      seg = ntm_forget_pkg::ONE_Q;
    else if (abs_z >= Z_MID) seg = (abs_z >> 5) + OFS_MID;
    else if (abs_z >= Z_LOW) seg = (abs_z >> 3) + OFS_LOW;
    else                     seg = (abs_z >> 2) + OFS_CTR;
  end

  assign stall       = f_valid && !f_ready;
  assign sum_s.ready = !s1_valid || !stall;  // Stage one free or moving on
  assign take        = sum_s.valid && sum_s.ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      f_valid  <= 1'b0;
    end else begin
      if (sum_s.ready) s1_valid <= take;
      if (!stall)      f_valid  <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (take) begin
      s1_seg  <= seg;
      s1_neg  <= sum_s.data[DATA_SIZE-1];
      s1_last <= sum_s.last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage two, mirror for negative z
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!stall) begin
      f_out  <= s1_neg ? ntm_forget_pkg::ONE_Q - s1_seg : s1_seg;  // 1 - s(|z|)
      f_last <= s1_last;
    end
  end

endmodule

// File: hdl/ntm_forget_gate_top.sv
/*
 * Forget-gate unit top level
 */

`timescale 1ns/10ps

module ntm_forget_gate_top #(
  parameter int DATA_SIZE = 16,
  parameter int SIZE_X    = 4,  // Input vector length
  parameter int SIZE_W    = 3,  // Read vector length
  parameter int SIZE_L    = 4   // Rows, also hidden length
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,

  // Operand stream
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [DATA_SIZE-1:0] in_a,
  input  logic [DATA_SIZE-1:0] in_b,

  // Forget-gate result stream
  output logic                 f_valid,
  input  logic                 f_ready,
  output logic [DATA_SIZE-1:0] f_out,
  output logic                 f_last
);

  ////////////////////////////////////////////////////////////
  // Internal streams
  ////////////////////////////////////////////////////////////

  ntm_stream_if #(.WIDTH(2*DATA_SIZE)) pair_s ();  // Operand pairs
  ntm_stream_if #(.WIDTH(DATA_SIZE))   sum_s ();   // Row sums z(l)

  logic done_beat;  // Last f of the vector leaves

  assign done_beat = f_valid && f_ready && f_last;

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  ntm_forget_gate_vector #(
    .DATA_SIZE (DATA_SIZE),
    .SIZE_X    (SIZE_X),
    .SIZE_W    (SIZE_W),
    .SIZE_L    (SIZE_L)
  ) u_ctrl (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .READY     (READY),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_a      (in_a),
    .in_b      (in_b),
    .done_beat (done_beat),
    .pair_s    (pair_s.source)
  );

  ntm_dot_product_accumulator #(
    .DATA_SIZE (DATA_SIZE),
    .SIZE_L    (SIZE_L)
  ) u_mac (
    .CLK    (CLK),
    .RST    (RST),
    .pair_s (pair_s.sink),
    .sum_s  (sum_s.source)
  );

  ntm_vector_logistic #(
    .DATA_SIZE (DATA_SIZE)
  ) u_logistic (
    .CLK     (CLK),
    .RST     (RST),
    .sum_s   (sum_s.sink),
    .f_valid (f_valid),
    .f_ready (f_ready),
    .f_out   (f_out),
    .f_last  (f_last)
  );

endmodule

// File: verification/ntm_forget_gate_checker.sv
/*
 * Forget-gate handshake assertions
 */

`timescale 1ns/10ps

module ntm_forget_gate_checker #(
  parameter int DATA_SIZE = 16
) (
  input logic                 CLK,
  input logic                 RST,
  input logic                 READY,
  input logic                 in_ready,
  input logic                 f_valid,
  input logic                 f_ready,
  input logic [DATA_SIZE-1:0] f_out,
  input logic                 f_last
);

  int fails = 0;  // Failed assertions so far

  // Result word held under back-pressure
  assert property (@(posedge CLK) disable iff (RST)
    f_valid && !f_ready |=> f_valid && $stable(f_out) && $stable(f_last))
    else begin
      $error("f stream changed while f_ready was low");
      fails++;
    end

  // Controller is idle on the done pulse
  assert property (@(posedge CLK) disable iff (RST) READY |-> !in_ready)
    else begin
      $error("in_ready high while READY is high");
      fails++;
    end

  // Done pulse only after the last f beat
  assert property (@(posedge CLK) disable iff (RST)
    READY |-> $past(f_valid && f_ready && f_last))
    else begin
      $error("READY without a preceding f_last handshake");
      fails++;
    end

endmodule

bind ntm_forget_gate_top ntm_forget_gate_checker #(
  .DATA_SIZE (DATA_SIZE)
) checker0 (
  .CLK      (CLK),
  .RST      (RST),
  .READY    (READY),
  .in_ready (in_ready),
  .f_valid  (f_valid),
  .f_ready  (f_ready),
  .f_out    (f_out),
  .f_last   (f_last)
);

// File: verification/ntm_forget_gate_tb.sv
/*
 * Forget-gate unit testbench
 */

`timescale 1ns/10ps

module ntm_forget_gate_tb;

  localparam int DATA_SIZE  = 16;
  localparam int SIZE_X     = 4;
  localparam int SIZE_W     = 3;
  localparam int SIZE_L     = 4;
  localparam int ROW_BEATS  = SIZE_X + SIZE_W + SIZE_L + 1;  // Operands plus bias
  localparam int TOTAL      = SIZE_L * ROW_BEATS;            // Beats per vector
  localparam int TEST_WORDS = 1 + TOTAL + SIZE_L;            // Flags, operands, f
  localparam int NUM_TESTS  = 5;
  localparam int CYCLE_LIMIT = NUM_TESTS * (SIZE_L * ROW_BEATS + 8) * 4;

  logic                 CLK = 1'b0;
  logic                 RST;
  logic                 START;
  logic                 READY;
  logic                 in_valid;
  logic                 in_ready;
  logic [DATA_SIZE-1:0] in_a;
  logic [DATA_SIZE-1:0] in_b;
  logic                 f_valid;
  logic                 f_ready;
  logic [DATA_SIZE-1:0] f_out;
  logic                 f_last;

  logic [31:0] tests_mem [0:NUM_TESTS*TEST_WORDS-1];
  logic [31:0] roll;                  // Random bits for gaps and stalls
  integer      seed = 32'hd0d8f720;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          ready_pulses = 0;

  always #5 CLK = ~CLK;  // 10 ns period

  ntm_forget_gate_top #(
    .DATA_SIZE (DATA_SIZE),
    .SIZE_X    (SIZE_X),
    .SIZE_W    (SIZE_W),
    .SIZE_L    (SIZE_L)
  ) dut0 (.*);

  ////////////////////////////////////////////////////////////
  // Watchdog with random source and READY counter
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    roll   <= $random(seed);  // Single draw per cycle
    cycles <= cycles + 1;
    if (READY) ready_pulses <= ready_pulses + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: no finish after %0d cycles, DUT stopped responding", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Operand source and result sink
  ////////////////////////////////////////////////////////////

  task automatic feed_operands(input int base, input logic gaps, input logic extra_start);
    int          idx;
    logic [31:0] word;
    idx = 0;
    while (idx < TOTAL) begin
      @(posedge CLK);
      if (in_valid && in_ready) idx++;             // Beat taken at this edge
      START <= extra_start && (idx == TOTAL / 2);  // Must be ignored mid-vector
      word = tests_mem[base + 1 + idx];
      if (in_valid && !in_ready) begin
        // Hold beat until taken
      end else if (idx < TOTAL && !(gaps && roll[0])) begin
        in_valid <= 1'b1;
        in_a     <= word[31:16];
        in_b     <= word[15:0];                    // Ignored on bias beat
      end else begin
        in_valid <= 1'b0;
      end
    end
    START <= 1'b0;
  endtask

  task automatic collect_results(input int base, input logic stall);
    int row;
    row = 0;
    while (row < SIZE_L) begin
      @(posedge CLK);
      if (f_valid && f_ready) begin
        check_value("f_out", f_out, tests_mem[base + 1 + TOTAL + row]);
        check_value("f_last", f_last, row == SIZE_L - 1);  // Last row only
        row++;
      end
      f_ready <= !(stall && roll[1]);
    end
    f_ready <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // One vector per test
  ////////////////////////////////////////////////////////////

  task automatic run_vector(input int t);
    int          base;
    int          err_before;
    int          pulses_before;
    logic [31:0] flags;
    base          = t * TEST_WORDS;
    flags         = tests_mem[base];
    err_before    = errors;
    pulses_before = ready_pulses;
    @(posedge CLK);
    check_value("in_ready", in_ready, 32'd0);  // Idle before START
    START <= 1'b1;
    @(posedge CLK);
    START <= 1'b0;
    fork
      feed_operands(base, flags[0], flags[2]);
      collect_results(base, flags[1]);
    join
    @(posedge CLK);
    check_value("READY", READY, 32'd1);        // Cycle after f_last beat
    repeat (2) @(posedge CLK);
    check_value("READY pulses", ready_pulses - pulses_before, 32'd1);
    check_value("f_valid", f_valid, 32'd0);    // No extra results
    check_value("in_ready", in_ready, 32'd0);  // Back in idle, stray START dropped
    $display("Test %0d (flags %0h): %0d rows, %0d errors", t + 1, flags[2:0],
             SIZE_L, errors - err_before);
  endtask

  initial begin
    RST      = 1'b1;
    START    = 1'b0;
    in_valid = 1'b0;
    in_a     = '0;
    in_b     = '0;
    f_ready  = 1'b1;
    $readmemh("verification/forget_gate_tests.txt", tests_mem);
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_vector(t);
    end
    errors += dut0.checker0.fails;  // Handshake assertions
    $display("Finished %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verification/forget_gate_tests.txt
// Per test: flag word (bit0 in_valid gaps, bit1 f_ready stalls, bit2 extra START),
// 4 rows of 12 words {a,b}: W x4, K x3, U x4, bias; then 4 expected f words
0
1000080 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 FF000200 0 0 0 0 0 0 400000
10003 FFFF0005 0 0 0 0 0 1800100 0 0 0 0
400040 0 0 0 0 0 0 0 0 0 0 FFC00000
A0 28 CF 74
0
7FFF7FFF 0 0 0 0 0 0 0 0 0 0 0
80007FFF 0 0 0 0 0 0 0 0 0 0 0
7FFF7FFF 7FFF7FFF 7FFF7FFF 7FFF7FFF 0 0 0 0 0 0 0 7FFF0000
0 0 0 0 80007FFF 80007FFF 80007FFF 0 0 0 0 80000000
100 0 100 0
0
1000100 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 FF000000
0 0 0 0 0 0 0 2600100 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 FDA00000
C0 40 EB 15
3
0 0 0 0 0 0 0 0 0 0 0 5000000
0 0 0 0 0 0 0 0 0 0 0 FB000000
0 0 0 0 0 4FF0100 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 FFFF0001 0
100 0 FF 80
5
0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 FF0000
0 0 0 0 0 0 0 0 0 0 0 FDA10000
2000100 0 0 0 0 0 F40200 0 0 0 0 0
80 BF 15 F7

// File: filelist.f
common/ntm_forget_pkg.sv
common/ntm_stream_if.sv
forget_gate/ntm_forget_gate_vector.sv
hdl/ntm_dot_product_accumulator.sv
hdl/ntm_vector_logistic.sv
hdl/ntm_forget_gate_top.sv
verification/ntm_forget_gate_checker.sv
verification/ntm_forget_gate_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := ntm_forget_gate_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := SIMULATION FAILED
PASS_MSG := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test: failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
